/* common/hough_pkg.sv */
package hough_pkg;

    // Frame geometry
    localparam int IMG_W      = 16;
    localparam int IMG_H      = 16;
    localparam int IMG_PIXELS = IMG_W * IMG_H;

    // Input buffer depth, equal to the credits the sender holds after reset
    localparam int PIX_CREDITS = 4;
    localparam int PIX_BUF_AW  = $clog2(PIX_CREDITS);

    localparam int EDGE_THRESH = 24;

    // Hough space
    localparam int N_THETA    = 4;
    localparam int RHO_BINS   = 32;
    localparam int RHO_OFFSET = 11;
    localparam int ACC_W      = 8;
    localparam int THETA_W    = $clog2(N_THETA);
    localparam int RHO_W      = $clog2(RHO_BINS);
    localparam int BIN_COUNT  = N_THETA * RHO_BINS;
    localparam int BIN_ADDR_W = $clog2(BIN_COUNT);

    // cos(45) in Q8, applied as a shift-add over its set bits
    localparam int COS45_Q8      = 181;
    localparam int COS_FRAC_BITS = 8;
    localparam int DIAG_W        = $clog2(IMG_W) + 2;
    localparam int DIAG_PROD_W   = DIAG_W + COS_FRAC_BITS;

    // Pipeline depth between the last scan and the first readout
    localparam int DRAIN_CYCLES = 2;
    localparam int OUT_CREDIT_W = 8;

    typedef struct packed {
        logic [7:0] red;
        logic [7:0] green;
        logic [7:0] blue;
    } rgb_t;

    // y above x, so the packed value is the raster address
    typedef struct packed {
        logic [$clog2(IMG_H)-1:0] y;
        logic [$clog2(IMG_W)-1:0] x;
    } pix_pos_t;

    typedef struct packed {
        pix_pos_t pos;
        logic     is_edge;
    } edge_pix_t;

    // rho[0] is 0 degrees, then 45, 90 and 135
    typedef struct packed {
        logic                            valid;
        logic [N_THETA-1:0][RHO_W-1:0]   rho;
    } vote_t;

    typedef struct packed {
        logic [THETA_W-1:0] theta;
        logic [RHO_W-1:0]   rho;
        logic [ACC_W-1:0]   count;
    } accum_bin_t;

    typedef enum logic [1:0] {
        LOAD,
        VOTE,
        READOUT
    } phase_t;

endpackage

/* hough/accum_bank.sv */
`timescale 1ns/1ps

module accum_bank
    import hough_pkg::*;
(
    input  logic               clock,
    input  logic               rst_n,
    input  vote_t              vote,
    input  logic               rd_en,
    input  logic [THETA_W-1:0] rd_theta,
    input  logic [RHO_W-1:0]   rd_rho,
    output logic [ACC_W-1:0]   rd_count
);

    logic [ACC_W-1:0]              acc [N_THETA][RHO_BINS];
    // Vote in the write stage and the counts it read
    vote_t                         upd;
    logic [N_THETA-1:0][ACC_W-1:0] upd_base;
    logic [N_THETA-1:0][ACC_W-1:0] rd_base;

    // Read stage; a hit on the write stage takes its new value
    always_comb begin
        for (int t = 0; t < N_THETA; t++) begin
            if (upd.valid && (upd.rho[t] == vote.rho[t])) begin
                rd_base[t] = upd_base[t] + 1'b1;
            end else begin
                rd_base[t] = acc[t][vote.rho[t]];
            end
        end
    end

    always_ff @(posedge clock) begin
        upd_base <= rd_base;
    end

    // Votes and readout never overlap, so one write path each is enough
    always_ff @(posedge clock) begin
        if (!rst_n) begin
            upd      <= '0;
            rd_count <= '0;
            for (int t = 0; t < N_THETA; t++) begin
                for (int r = 0; r < RHO_BINS; r++) begin
                    acc[t][r] <= '0;
                end
            end
        end else begin
            upd <= vote;
            if (upd.valid) begin
                for (int t = 0; t < N_THETA; t++) begin
                    acc[t][upd.rho[t]] <= upd_base[t] + 1'b1;
                end
            end
            // Read and clear leaves the bank empty for the next frame
            if (rd_en) begin
                rd_count               <= acc[rd_theta][rd_rho];
                acc[rd_theta][rd_rho]  <= '0;
            end
        end
    end

endmodule

/* hough/hough_ctrl.sv */
`timescale 1ns/1ps

module hough_ctrl
    import hough_pkg::*;
(
    input  logic               clock,
    input  logic               rst_n,
    input  logic               pix_accept,
    output phase_t             phase,
    output pix_pos_t           scan_pos,
    output logic [THETA_W-1:0] rd_theta,
    output logic [RHO_W-1:0]   rd_rho,
    output logic               rd_en,
    input  logic [ACC_W-1:0]   rd_count,
    input  logic               bin_credit,
    output logic               bin_valid,
    output accum_bin_t         bin,
    output logic               done
);

    logic [$clog2(IMG_PIXELS)-1:0]     pix_cnt;
    logic [$clog2(IMG_PIXELS)-1:0]     scan_cnt;
    logic [$clog2(DRAIN_CYCLES+1)-1:0] drain_cnt;
    // Top bit set once every bin address has been issued
    logic [BIN_ADDR_W:0]               rd_addr;
    logic [OUT_CREDIT_W-1:0]           out_credits;
    logic [THETA_W-1:0]                bin_theta;
    logic [RHO_W-1:0]                  bin_rho;
    logic                              bin_last;

    assign scan_pos = pix_pos_t'(scan_cnt);

    // Theta is the major index of the readout order
    assign rd_theta = rd_addr[BIN_ADDR_W-1 -: THETA_W];
    assign rd_rho   = rd_addr[RHO_W-1:0];

    // First DRAIN_CYCLES of READOUT let the last votes land in the banks
    assign rd_en = (phase == READOUT) && (drain_cnt == DRAIN_CYCLES)
                && !rd_addr[BIN_ADDR_W] && (out_credits != '0);

    assign bin = '{theta: bin_theta, rho: bin_rho, count: rd_count};

    always_ff @(posedge clock) begin
        if (!rst_n) begin
            phase       <= LOAD;
            pix_cnt     <= '0;
            scan_cnt    <= '0;
            drain_cnt   <= '0;
            rd_addr     <= '0;
            out_credits <= '0;
            bin_valid   <= 1'b0;
            bin_last    <= 1'b0;
            done        <= 1'b0;
        end else begin
            out_credits <= out_credits + bin_credit - rd_en;
            bin_valid   <= rd_en;
            bin_last    <= rd_en && (rd_addr[BIN_ADDR_W-1:0] == BIN_COUNT - 1);
            done        <= bin_valid && bin_last;

            case (phase)
                LOAD: begin
                    if (pix_accept) begin
                        pix_cnt <= pix_cnt + 1'b1;
                        if (pix_cnt == IMG_PIXELS - 1) begin
                            phase    <= VOTE;
                            scan_cnt <= '0;
                        end
                    end
                end
                VOTE: begin
                    scan_cnt <= scan_cnt + 1'b1;
                    if (scan_cnt == IMG_PIXELS - 1) begin
                        phase     <= READOUT;
                        drain_cnt <= '0;
                        rd_addr   <= '0;
                    end
                end
                READOUT: begin
                    if (drain_cnt != DRAIN_CYCLES) begin
                        drain_cnt <= drain_cnt + 1'b1;
                    end
                    if (rd_en) begin
                        rd_addr <= rd_addr + 1'b1;
                    end
                    // Back to LOAD together with the done pulse
                    if (bin_valid && bin_last) begin
                        phase <= LOAD;
                    end
                end
                default: phase <= LOAD;
            endcase
        end
    end

    // Address of the bin whose count returns next cycle
    always_ff @(posedge clock) begin
        if (rd_en) begin
            bin_theta <= rd_theta;
            bin_rho   <= rd_rho;
        end
    end

endmodule

/* hough/hough_voter.sv */
`timescale 1ns/1ps

module hough_voter
    import hough_pkg::*;
(
    input  logic      clock,
    input  logic      rst_n,
    input  logic      edge_wr,
    input  edge_pix_t edge_pix,
    input  phase_t    phase,
    input  pix_pos_t  scan_pos,
    output vote_t     vote
);

    logic [IMG_PIXELS-1:0]         edge_map;
    logic signed [DIAG_W-1:0]      sum_xy;
    logic signed [DIAG_W-1:0]      diff_yx;
    logic [N_THETA-1:0][RHO_W-1:0] rho_next;
    logic [N_THETA-1:0][RHO_W-1:0] vote_rho;
    logic                          vote_valid;

    // Multiply by cos(45) with one shifted add per set bit, then floor
    function automatic logic [RHO_W-1:0] diag_rho(input logic signed [DIAG_W-1:0] v);
        logic signed [DIAG_PROD_W-1:0] w;
        logic signed [DIAG_PROD_W-1:0] prod;
        w    = DIAG_PROD_W'(v);
        prod = '0;
        for (int i = 0; i < COS_FRAC_BITS; i++) begin
            if (COS45_Q8[i]) begin
                prod = prod + (w <<< i);
            end
        end
        return RHO_W'((prod >>> COS_FRAC_BITS) + RHO_OFFSET);
    endfunction

    assign sum_xy  = DIAG_W'(scan_pos.x) + DIAG_W'(scan_pos.y);
    assign diff_yx = DIAG_W'(scan_pos.y) - DIAG_W'(scan_pos.x);

    // Corner 15,15 reaches 32 at 45 degrees and wraps into bin 0
    assign rho_next[0] = RHO_W'(scan_pos.x + RHO_OFFSET);
    assign rho_next[1] = diag_rho(sum_xy);
    assign rho_next[2] = RHO_W'(scan_pos.y + RHO_OFFSET);
    assign rho_next[3] = diag_rho(diff_yx);

    assign vote = '{valid: vote_valid, rho: vote_rho};

    // Every entry is rewritten each frame before it is scanned
    always_ff @(posedge clock) begin
        if (edge_wr) begin
            edge_map[{edge_pix.pos.y, edge_pix.pos.x}] <= edge_pix.is_edge;
        end
    end

    always_ff @(posedge clock) begin
        if (!rst_n) begin
            vote_valid <= 1'b0;
        end else begin
            vote_valid <= (phase == VOTE) && edge_map[{scan_pos.y, scan_pos.x}];
        end
    end

    always_ff @(posedge clock) begin
        vote_rho <= rho_next;
    end

endmodule

/* hw/hough_top.sv */
`timescale 1ns/1ps

module hough_top
    import hough_pkg::*;
(
    input  logic       clock,
    input  logic       rst_n,
    // Pixel stream in
    input  logic       pix_valid,
    input  rgb_t       pix,
    output logic       pix_credit,
    // Accumulator bins out
    output logic       bin_valid,
    output accum_bin_t bin,
    input  logic       bin_credit,
    output logic       done
);

    phase_t             phase;
    logic               pix_accept;
    logic               edge_wr;
    edge_pix_t          edge_pix;
    pix_pos_t           scan_pos;
    vote_t              vote;
    logic               rd_en;
    logic [THETA_W-1:0] rd_theta;
    logic [RHO_W-1:0]   rd_rho;
    logic [ACC_W-1:0]   rd_count;

    pixel_filter pixel_filter_inst (
        .clock      (clock),
        .rst_n      (rst_n),
        .pix_valid  (pix_valid),
        .pix        (pix),
        .pix_credit (pix_credit),
        .phase      (phase),
        .edge_wr    (edge_wr),
        .edge_pix   (edge_pix),
        .pix_accept (pix_accept)
    );

    hough_ctrl hough_ctrl_inst (
        .clock      (clock),
        .rst_n      (rst_n),
        .pix_accept (pix_accept),
        .phase      (phase),
        .scan_pos   (scan_pos),
        .rd_theta   (rd_theta),
        .rd_rho     (rd_rho),
        .rd_en      (rd_en),
        .rd_count   (rd_count),
        .bin_credit (bin_credit),
        .bin_valid  (bin_valid),
        .bin        (bin),
        .done       (done)
    );

    hough_voter hough_voter_inst (
        .clock    (clock),
        .rst_n    (rst_n),
        .edge_wr  (edge_wr),
        .edge_pix (edge_pix),
        .phase    (phase),
        .scan_pos (scan_pos),
        .vote     (vote)
    );

    accum_bank accum_bank_inst (
        .clock    (clock),
        .rst_n    (rst_n),
        .vote     (vote),
        .rd_en    (rd_en),
        .rd_theta (rd_theta),
        .rd_rho   (rd_rho),
        .rd_count (rd_count)
    );

endmodule

/* hw/pixel_filter.sv */
`timescale 1ns/1ps

module pixel_filter
    import hough_pkg::*;
(
    input  logic      clock,
    input  logic      rst_n,
    input  logic      pix_valid,
    input  rgb_t      pix,
    output logic      pix_credit,
    input  phase_t    phase,
    output logic      edge_wr,
    output edge_pix_t edge_pix,
    output logic      pix_accept
);

    rgb_t                  buf_mem [PIX_CREDITS];
    logic [PIX_BUF_AW-1:0] wr_ptr;
    logic [PIX_BUF_AW-1:0] rd_ptr;
    logic [PIX_BUF_AW:0]   fill;
    rgb_t                  head;
    logic                  pop;
    logic [15:0]           gray_sum;
    logic [7:0]            gray;
    logic [7:0]            prev_gray;
    logic [7:0]            gray_diff;
    pix_pos_t              pos;

    assign head = buf_mem[rd_ptr];

    // Pixels of the next frame wait in the buffer until the phase is back to LOAD
    assign pop        = (fill != '0) && (phase == LOAD);
    assign pix_accept = pop;

    // Luma weights 77/150/29 sum to 256
    assign gray_sum  = 16'(77 * head.red + 150 * head.green + 29 * head.blue);
    assign gray      = gray_sum[15:8];
    assign gray_diff = (gray > prev_gray) ? gray - prev_gray : prev_gray - gray;

    // The sender never exceeds its credits, so a push always finds room
    always_ff @(posedge clock) begin
        if (pix_valid) begin
            buf_mem[wr_ptr] <= pix;
        end
    end

    always_ff @(posedge clock) begin
        if (!rst_n) begin
            wr_ptr     <= '0;
            rd_ptr     <= '0;
            fill       <= '0;
            pos        <= '0;
            edge_wr    <= 1'b0;
            pix_credit <= 1'b0;
        end else begin
            wr_ptr     <= wr_ptr + pix_valid;
            fill       <= fill + pix_valid - pop;
            edge_wr    <= pop;
            pix_credit <= pop;
            if (pop) begin
                rd_ptr <= rd_ptr + 1'b1;
                // Raster counter wraps to 0,0 at the end of a frame
                pos    <= pix_pos_t'(pos + 1'b1);
            end
        end
    end

    // Left neighbour compare; the first column never marks an edge
    always_ff @(posedge clock) begin
        if (pop) begin
            prev_gray <= gray;
            edge_pix  <= '{pos: pos, is_edge: (pos.x != '0) && (gray_diff > EDGE_THRESH)};
        end
    end

endmodule

/* list.f */
+incdir+verif
common/hough_pkg.sv
hw/pixel_filter.sv
hough/hough_ctrl.sv
hough/hough_voter.sv
hough/accum_bank.sv
hw/hough_top.sv
verif/tb_hough_top.sv

/* run_sim.sh */
#!/usr/bin/env bash
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log
verilator --binary --timing -Wno-fatal --top-module tb_hough_top -f list.f -o tb_hough_top \
    && ./obj_dir/tb_hough_top > sim.log 2>&1 \
    || { cat sim.log 2>/dev/null; echo "Build or simulation run failed"; exit 1; }
cat sim.log
grep -q "Finished with errors" sim.log \
    && { echo "Simulation failed"; exit 1; } \
    || { echo "Simulation passed"; exit 0; }

/* verif/hough_model.svh */
`ifndef HOUGH_MODEL_SVH
`define HOUGH_MODEL_SVH

// Reference frame in raster order and the bin counts it should produce
rgb_t model_pix [IMG_PIXELS];
int   model_count [N_THETA][RHO_BINS];

function automatic int gray_level(input rgb_t p);
    return (77 * int'(p.red) + 150 * int'(p.green) + 29 * int'(p.blue)) >> 8;
endfunction

// Theta index 0..3 stands for 0, 45, 90 and 135 degrees
function automatic int rho_bin(input int theta, input int x, input int y);
    int rho;
    case (theta)
        0: rho = x;
        1: rho = ((x + y) * COS45_Q8) >>> 8;
        2: rho = y;
        default: rho = ((y - x) * COS45_Q8) >>> 8;
    endcase
    // Bin index is RHO_W bits wide, so the 45 degree corner at 15,15 wraps to bin 0
    return (rho + RHO_OFFSET) % RHO_BINS;
endfunction

function automatic logic edge_at(input int x, input int y);
    int diff;
    if (x == 0) begin
        return 1'b0;
    end
    diff = gray_level(model_pix[y * IMG_W + x]) - gray_level(model_pix[y * IMG_W + x - 1]);
    if (diff < 0) begin
        diff = -diff;
    end
    return diff > EDGE_THRESH;
endfunction

// Each frame starts from empty accumulators
task automatic count_votes();
    for (int t = 0; t < N_THETA; t++) begin
        for (int r = 0; r < RHO_BINS; r++) begin
            model_count[t][r] = 0;
        end
    end
    for (int y = 0; y < IMG_H; y++) begin
        for (int x = 0; x < IMG_W; x++) begin
            if (edge_at(x, y)) begin
                for (int t = 0; t < N_THETA; t++) begin
                    model_count[t][rho_bin(t, x, y)]++;
                end
            end
        end
    end
endtask

`endif

/* verif/tb_hough_top.sv */
`timescale 1ns/1ps

module tb_hough_top
    import hough_pkg::*;
();

    localparam int N_FRAMES       = 3;
    localparam int OUT_CREDIT_CAP = 6;
    localparam int CREDIT_GAPS    = 1024;

    logic       clock;
    logic       rst_n;
    logic       pix_valid;
    rgb_t       pix;
    logic       pix_credit;
    logic       bin_valid;
    accum_bin_t bin;
    logic       bin_credit;
    logic       done;

    int         seed;
    int         value_errors;
    int         protocol_errors;
    int         bins_checked;
    int         pix_sent;
    int         pix_returned;
    int         credits_given;
    int         bins_seen;
    int         frame_bins;
    int         done_seen;
    logic       prev_bin_valid;
    int         credit_gap [CREDIT_GAPS];
    accum_bin_t exp_q [$];

    `include "hough_model.svh"

    hough_top hough_top_inst (
        .clock      (clock),
        .rst_n      (rst_n),
        .pix_valid  (pix_valid),
        .pix        (pix),
        .pix_credit (pix_credit),
        .bin_valid  (bin_valid),
        .bin        (bin),
        .bin_credit (bin_credit),
        .done       (done)
    );

    initial clock = 1'b0;
    always #50 clock = ~clock;

    task automatic report_protocol_error(input string msg);
        protocol_errors++;
        $display("Protocol error at %0t: %s", $time, msg);
    endtask

    task automatic compare_bin(input accum_bin_t got, input accum_bin_t want);
        bins_checked++;
        if (got !== want) begin
            value_errors++;
            $display("FAIL %0t: bin %0d/%0d count %0d, expected bin %0d/%0d count %0d",
                     $time, got.theta, got.rho, got.count, want.theta, want.rho, want.count);
        end
    endtask

    task automatic compare_done(input logic got, input logic want);
        if (got !== want) begin
            value_errors++;
            $display("FAIL %0t: done is %b, expected %b", $time, got, want);
        end
    endtask

    function automatic logic [7:0] jitter(input logic [7:0] c);
        logic [7:0] d;
        d = 8'({$random(seed)} % 32);
        return c + d - 8'd16;
    endfunction

    // Mostly small steps from the left pixel, with an occasional jump
    function automatic rgb_t next_pixel(input rgb_t left);
        rgb_t p;
        if (({$random(seed)} % 4) == 0) begin
            p = 24'($random(seed));
        end else begin
            p.red   = jitter(left.red);
            p.green = jitter(left.green);
            p.blue  = jitter(left.blue);
        end
        return p;
    endfunction

    task automatic send_pixel(input rgb_t p, input int gap);
        repeat (gap) begin
            @(posedge clock);
            #1;
        end
        while (PIX_CREDITS - (pix_sent - pix_returned) == 0) begin
            @(posedge clock);
            #1;
        end
        pix_valid = 1'b1;
        pix       = p;
        pix_sent++;
        @(posedge clock);
        #1;
        pix_valid = 1'b0;
    endtask

    // Output credits trickle in with random gaps, a few outstanding at most
    initial begin
        int gap_idx;
        bin_credit = 1'b0;
        gap_idx    = 0;
        wait (rst_n === 1'b1);
        forever begin
            repeat (credit_gap[gap_idx]) begin
                @(posedge clock);
                #1;
            end
            gap_idx = (gap_idx + 1) % CREDIT_GAPS;
            if (credits_given - bins_seen < OUT_CREDIT_CAP) begin
                bin_credit = 1'b1;
                credits_given++;
            end
            @(posedge clock);
            #1;
            bin_credit = 1'b0;
        end
    end

    // Outputs settle after the rising edge, so they are sampled on the falling edge
    always @(negedge clock) begin
        if (rst_n) begin
            if (pix_sent == 0 && (bin_valid !== 1'b0 || pix_credit !== 1'b0 || done !== 1'b0)) begin
                report_protocol_error("output active before the first pixel was sent");
            end
            if (pix_credit) begin
                pix_returned++;
                if (pix_returned > pix_sent) begin
                    report_protocol_error("more pixel credits returned than pixels sent");
                end
            end
            compare_done(done, prev_bin_valid && (frame_bins == BIN_COUNT));
            if (done) begin
                done_seen++;
                frame_bins = 0;
            end
            if (bin_valid) begin
                if (credits_given - bins_seen <= 0) begin
                    report_protocol_error("bin_valid asserted without an output credit");
                end
                bins_seen++;
                frame_bins++;
                if (exp_q.size() == 0) begin
                    report_protocol_error("bin received with no bin expected");
                end else begin
                    compare_bin(bin, exp_q.pop_front());
                end
            end
            prev_bin_valid = bin_valid;
        end
    end

    initial begin
        repeat (N_FRAMES * (IMG_PIXELS + IMG_PIXELS + DRAIN_CYCLES + BIN_COUNT) * 8) begin
            @(posedge clock);
        end
        $display("Timeout: the frames did not complete in time, stopped at %0t", $time);
        $display("Finished with errors");
        $finish;
    end

    initial begin
        rgb_t       left;
        accum_bin_t eb;
        seed            = 80488;
        value_errors    = 0;
        protocol_errors = 0;
        bins_checked    = 0;
        pix_sent        = 0;
        pix_returned    = 0;
        credits_given   = 0;
        bins_seen       = 0;
        frame_bins      = 0;
        done_seen       = 0;
        prev_bin_valid  = 1'b0;
        rst_n           = 1'b0;
        pix_valid       = 1'b0;
        pix             = '0;
        for (int i = 0; i < CREDIT_GAPS; i++) begin
            credit_gap[i] = {$random(seed)} % 8;
        end
        repeat (2) @(posedge clock);
        #1;
        rst_n = 1'b1;

        // Quiet cycles after reset before the first pixel
        repeat (4) @(posedge clock);
        #1;

        for (int frame = 0; frame < N_FRAMES; frame++) begin
            left = 24'($random(seed));
            for (int i = 0; i < IMG_PIXELS; i++) begin
                model_pix[i] = next_pixel(left);
                left         = model_pix[i];
            end
            count_votes();
            for (int t = 0; t < N_THETA; t++) begin
                for (int r = 0; r < RHO_BINS; r++) begin
                    eb.theta = THETA_W'(t);
                    eb.rho   = RHO_W'(r);
                    eb.count = ACC_W'(model_count[t][r]);
                    exp_q.push_back(eb);
                end
            end
            for (int i = 0; i < IMG_PIXELS; i++) begin
                send_pixel(model_pix[i], {$random(seed)} % 4);
            end
            while (done_seen <= frame) begin
                @(posedge clock);
            end
            #1;
            if (pix_sent != pix_returned) begin
                report_protocol_error("input credits not all returned at the end of a frame");
            end
        end

        repeat (8) @(posedge clock);
        if (exp_q.size() != 0) begin
            report_protocol_error("fewer bins received than expected");
        end
        if (done_seen != N_FRAMES) begin
            report_protocol_error("done count differs from the number of frames");
        end
        $display("Summary: %0d bins checked, %0d value errors, %0d protocol errors",
                 bins_checked, value_errors, protocol_errors);
        if (value_errors + protocol_errors == 0) begin
            $display("Finished with no errors");
        end else begin
            $display("Finished with errors");
        end
        $finish;
    end

endmodule
